/* hdl/mm_cfg.svh */
`ifndef MM_CFG_SVH
`define MM_CFG_SVH

// ram size as a byte-address width
`define MM_RAM_ADDR_WIDTH 16
`define MM_WORD_WIDTH 32

// test status and exit registers
`define MM_TEST_STATUS_ADDR 32'h2000_0000
`define MM_EXIT_ADDR 32'h2000_0004

// timer registers
`define MM_TIMER_MASK_ADDR 32'h1500_0000
`define MM_TIMER_CNT_ADDR 32'h1500_0004

// values written to the test status register
`define MM_PASS_MAGIC 32'd123456789
`define MM_FAIL_MAGIC 32'd1

`define MM_TIMER_IRQ_ID 7

`endif

/* hdl/mm_map_pkg.sv */
`include "mm_cfg.svh"

package mm_map_pkg;

  // where a data access lands
  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_HOST,
    REGION_ERR,
    REGION_NONE
  } region_e;

  // address seen as an offset into the ram
  typedef struct packed {
    logic [`MM_WORD_WIDTH-`MM_RAM_ADDR_WIDTH-1:0] upper;
    logic [`MM_RAM_ADDR_WIDTH-1:0]                offset;
  } ram_view_t;

  // address seen as a register page and offset
  typedef struct packed {
    logic [15:0] page;
    logic [15:0] offset;
  } reg_view_t;

  typedef union packed {
    ram_view_t ram_view;
    reg_view_t reg_view;
  } data_addr_u;

endpackage

/* hdl/mm_irq_pkg.sv */
`include "mm_cfg.svh"

package mm_irq_pkg;

  // interrupt id as acknowledged by the core
  typedef logic [4:0] irq_id_t;

  // down-counting timer value
  typedef logic [`MM_WORD_WIDTH-1:0] timer_cnt_t;

endpackage

/* hdl/mm_data_if.sv */
`include "mm_cfg.svh"

interface mm_data_if;
  import mm_map_pkg::*;

  // high only for accepted accesses
  logic                        req;
  logic                        we;
  logic [`MM_WORD_WIDTH/8-1:0] be;
  logic [`MM_WORD_WIDTH-1:0]   wdata;
  data_addr_u                  addr;
  region_e                     region;

  modport decode (
    output req,
    output we,
    output be,
    output wdata,
    output addr,
    output region
  );

  modport access (
    input req,
    input we,
    input be,
    input wdata,
    input addr,
    input region
  );

  modport resp (
    input req,
    input region
  );

endinterface

/* hdl/mm_addr_decode.sv */
`include "mm_cfg.svh"

module mm_addr_decode (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        data_req_i,
  input  logic [`MM_WORD_WIDTH-1:0]   data_addr_i,
  input  logic                        data_we_i,
  input  logic [`MM_WORD_WIDTH/8-1:0] data_be_i,
  input  logic [`MM_WORD_WIDTH-1:0]   data_wdata_i,
  output logic                        data_gnt_o,
  mm_data_if.decode                   dec
);
  import mm_map_pkg::*;

  data_addr_u addr;
  logic       is_host;
  region_e    region;

  assign addr = data_addr_i;

  // only the four register words are mapped outside the ram
  assign is_host = (data_addr_i == `MM_TEST_STATUS_ADDR) ||
                   (data_addr_i == `MM_EXIT_ADDR) ||
                   (data_addr_i == `MM_TIMER_MASK_ADDR) ||
                   (data_addr_i == `MM_TIMER_CNT_ADDR);

  always_comb begin
    region = REGION_NONE;
    if (data_req_i) begin
      if (addr.ram_view.upper == '0) begin
        region = REGION_RAM;
      end else if (is_host) begin
        region = REGION_HOST;
      end else begin
        region = REGION_ERR;
      end
    end
  end

  // memory is always ready, so every mapped request is granted at once
  assign data_gnt_o = (region == REGION_RAM) || (region == REGION_HOST);

  assign dec.req    = data_gnt_o;
  assign dec.we     = data_we_i;
  assign dec.be     = data_be_i;
  assign dec.wdata  = data_wdata_i;
  assign dec.addr   = addr;
  assign dec.region = region;

  // the core must never store outside the map
  unmapped_write_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_i && data_we_i |-> region != REGION_ERR
  ) else $error("unmapped write to %08x with %08x", data_addr_i, data_wdata_i);

endmodule

/* hdl/mm_ram_bank.sv */
`include "mm_cfg.svh"

module mm_ram_bank #(
  parameter int ADDR_WIDTH = `MM_RAM_ADDR_WIDTH
) (
  input  logic                      clk_i,
  input  logic                      instr_req_i,
  input  logic [ADDR_WIDTH-1:0]     instr_addr_i,
  output logic [`MM_WORD_WIDTH-1:0] instr_rdata_o,
  output logic [`MM_WORD_WIDTH-1:0] data_rdata_o,
  mm_data_if.access                 acc
);
  import mm_map_pkg::*;

  localparam int NUM_WORDS = 2 ** (ADDR_WIDTH - 2);

  logic [`MM_WORD_WIDTH-1:0] mem [NUM_WORDS];
  logic [ADDR_WIDTH-3:0]     instr_idx;
  logic [ADDR_WIDTH-3:0]     data_idx;
  logic                      data_en;

  // word index, byte offset dropped
  assign instr_idx = instr_addr_i[ADDR_WIDTH-1:2];
  assign data_idx  = acc.addr.ram_view.offset[ADDR_WIDTH-1:2];
  assign data_en   = acc.req && (acc.region == REGION_RAM);

  // read-only fetch port
  always_ff @(posedge clk_i) begin
    if (instr_req_i) begin
      instr_rdata_o <= mem[instr_idx];
    end
  end

  // data port returns the old word on a write
  always_ff @(posedge clk_i) begin
    if (data_en) begin
      data_rdata_o <= mem[data_idx];
      if (acc.we) begin
        for (int b = 0; b < `MM_WORD_WIDTH / 8; b++) begin
          if (acc.be[b]) begin
            mem[data_idx][8*b +: 8] <= acc.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // byte lanes come from be, so the address itself stays word aligned
  ram_aligned_a : assert property (
    @(posedge clk_i) data_en |-> acc.addr.ram_view.offset[1:0] == 2'b00
  ) else $error("misaligned ram access at %08x", acc.addr);

endmodule

/* hdl/mm_host_regs.sv */
`include "mm_cfg.svh"

module mm_host_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  mm_data_if.access                 acc,
  input  mm_irq_pkg::irq_id_t       irq_id_i,
  input  logic                      irq_ack_i,
  output logic                      tests_passed_o,
  output logic                      tests_failed_o,
  output logic                      exit_valid_o,
  output logic [`MM_WORD_WIDTH-1:0] exit_value_o,
  output logic                      irq_timer_o
);
  import mm_map_pkg::*;
  import mm_irq_pkg::*;

  localparam data_addr_u STATUS_ADDR = `MM_TEST_STATUS_ADDR;
  localparam data_addr_u EXIT_ADDR   = `MM_EXIT_ADDR;
  localparam data_addr_u MASK_ADDR   = `MM_TIMER_MASK_ADDR;
  localparam data_addr_u CNT_ADDR    = `MM_TIMER_CNT_ADDR;

  logic                      host_we;
  logic                      status_sel;
  logic                      exit_sel;
  logic                      mask_sel;
  logic                      cnt_sel;
  logic [`MM_WORD_WIDTH-1:0] mask_q;
  timer_cnt_t                cnt_q;
  logic                      irq_q;
  logic                      timer_ack;

  // page and register offset both have to match
  function automatic logic reg_hit(data_addr_u a, data_addr_u r);
    return (a.reg_view.page == r.reg_view.page) && (a.reg_view.offset == r.reg_view.offset);
  endfunction

  assign host_we    = acc.req && acc.we && (acc.region == REGION_HOST);
  assign status_sel = host_we && reg_hit(acc.addr, STATUS_ADDR);
  assign exit_sel   = host_we && reg_hit(acc.addr, EXIT_ADDR);
  assign mask_sel   = host_we && reg_hit(acc.addr, MASK_ADDR);
  assign cnt_sel    = host_we && reg_hit(acc.addr, CNT_ADDR);

  // strobes live only during the granted write
  assign tests_passed_o = status_sel && (acc.wdata == `MM_PASS_MAGIC);
  assign tests_failed_o = status_sel && (acc.wdata == `MM_FAIL_MAGIC);
  assign exit_valid_o   = exit_sel;
  assign exit_value_o   = exit_sel ? acc.wdata : '0;

  assign timer_ack = irq_ack_i && (irq_id_i == irq_id_t'(`MM_TIMER_IRQ_ID));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
    end else begin
      if (mask_sel) begin
        mask_q <= acc.wdata;
      end
      if (cnt_sel) begin
        cnt_q <= acc.wdata;
      end else if (!mask_sel && cnt_q != '0) begin
        cnt_q <= cnt_q - timer_cnt_t'(1);
        // irq shows up together with the zero count
        if (cnt_q == timer_cnt_t'(1) && mask_q[`MM_TIMER_IRQ_ID]) begin
          irq_q <= 1'b1;
        end
      end
      // an ack takes priority over a new expiry
      if (timer_ack) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign irq_timer_o = irq_q;

endmodule

/* hdl/mm_resp_stage.sv */
`include "mm_cfg.svh"

module mm_resp_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  mm_data_if.resp                   rsp,
  input  logic                      instr_req_i,
  input  logic [`MM_WORD_WIDTH-1:0] ram_rdata_i,
  output logic                      instr_rvalid_o,
  output logic                      data_rvalid_o,
  output logic [`MM_WORD_WIDTH-1:0] data_rdata_o
);
  import mm_map_pkg::*;

  logic    instr_rvalid_q;
  logic    data_rvalid_q;
  region_e region_q;

  // one response per accepted request, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rvalid_q <= 1'b0;
      data_rvalid_q  <= 1'b0;
      region_q       <= REGION_NONE;
    end else begin
      instr_rvalid_q <= instr_req_i;
      data_rvalid_q  <= rsp.req;
      region_q       <= rsp.region;
    end
  end

  assign instr_rvalid_o = instr_rvalid_q;
  assign data_rvalid_o  = data_rvalid_q;

  // host registers read as zero
  assign data_rdata_o = (region_q == REGION_RAM) ? ram_rdata_i : '0;

  // a response only follows a request that decode mapped and granted
  rvalid_after_gnt_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_o |-> (region_q == REGION_RAM) || (region_q == REGION_HOST)
  ) else $error("data rvalid without a grant in the previous cycle");

endmodule

/* hdl/mm_ram.sv */
`include "mm_cfg.svh"

module mm_ram (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          instr_req_i,
  input  logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_i,
  output logic                          instr_gnt_o,
  output logic                          instr_rvalid_o,
  output logic [`MM_WORD_WIDTH-1:0]     instr_rdata_o,

  input  logic                          data_req_i,
  input  logic [`MM_WORD_WIDTH-1:0]     data_addr_i,
  input  logic                          data_we_i,
  input  logic [`MM_WORD_WIDTH/8-1:0]   data_be_i,
  input  logic [`MM_WORD_WIDTH-1:0]     data_wdata_i,
  output logic                          data_gnt_o,
  output logic                          data_rvalid_o,
  output logic [`MM_WORD_WIDTH-1:0]     data_rdata_o,

  input  mm_irq_pkg::irq_id_t           irq_id_i,
  input  logic                          irq_ack_i,
  output logic                          irq_timer_o,

  output logic                          tests_passed_o,
  output logic                          tests_failed_o,
  output logic                          exit_valid_o,
  output logic [`MM_WORD_WIDTH-1:0]     exit_value_o
);

  logic [`MM_WORD_WIDTH-1:0] ram_rdata;

  mm_data_if data_if ();

  // fetches never stall
  assign instr_gnt_o = instr_req_i;

  mm_addr_decode decode_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .data_req_i  (data_req_i),
    .data_addr_i (data_addr_i),
    .data_we_i   (data_we_i),
    .data_be_i   (data_be_i),
    .data_wdata_i(data_wdata_i),
    .data_gnt_o  (data_gnt_o),
    .dec         (data_if.decode)
  );

  mm_ram_bank #(
    .ADDR_WIDTH(`MM_RAM_ADDR_WIDTH)
  ) ram_bank_i (
    .clk_i        (clk_i),
    .instr_req_i  (instr_req_i),
    .instr_addr_i (instr_addr_i),
    .instr_rdata_o(instr_rdata_o),
    .data_rdata_o (ram_rdata),
    .acc          (data_if.access)
  );

  mm_host_regs host_regs_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acc           (data_if.access),
    .irq_id_i      (irq_id_i),
    .irq_ack_i     (irq_ack_i),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .irq_timer_o   (irq_timer_o)
  );

  mm_resp_stage resp_stage_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rsp           (data_if.resp),
    .instr_req_i   (instr_req_i),
    .ram_rdata_i   (ram_rdata),
    .instr_rvalid_o(instr_rvalid_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o)
  );

endmodule

/* verification/tb_mm_ram.sv */
`include "mm_cfg.svh"

module tb_mm_ram;
  timeunit 1ns;
  timeprecision 1ps;

  import mm_irq_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int FILL_WORDS   = 16;
  localparam int RANDOM_OPS   = 200;
  localparam int TIMER_MAX    = 8;
  // all phases plus the idle cycles between them
  localparam int TEST_CYCLES  = RESET_CYCLES + 2 * FILL_WORDS + RANDOM_OPS + 4 * TIMER_MAX + 40;
  localparam int WORDS        = 2 ** (`MM_RAM_ADDR_WIDTH - 2);

  logic                          clk_i;
  logic                          rst_ni;
  logic                          instr_req_i;
  logic [`MM_RAM_ADDR_WIDTH-1:0] instr_addr_i;
  logic                          instr_gnt_o;
  logic                          instr_rvalid_o;
  logic [`MM_WORD_WIDTH-1:0]     instr_rdata_o;
  logic                          data_req_i;
  logic [`MM_WORD_WIDTH-1:0]     data_addr_i;
  logic                          data_we_i;
  logic [`MM_WORD_WIDTH/8-1:0]   data_be_i;
  logic [`MM_WORD_WIDTH-1:0]     data_wdata_i;
  logic                          data_gnt_o;
  logic                          data_rvalid_o;
  logic [`MM_WORD_WIDTH-1:0]     data_rdata_o;
  irq_id_t                       irq_id_i;
  logic                          irq_ack_i;
  logic                          irq_timer_o;
  logic                          tests_passed_o;
  logic                          tests_failed_o;
  logic                          exit_valid_o;
  logic [`MM_WORD_WIDTH-1:0]     exit_value_o;

  // reference copy of the ram contents
  logic [31:0]                   model_mem [WORDS];
  logic [`MM_RAM_ADDR_WIDTH-3:0] word_idx [FILL_WORDS];

  // what the DUT has to answer one cycle after the current request
  logic        pend_dvalid;
  logic        pend_dread;
  logic [31:0] pend_drdata;
  logic        pend_ivalid;
  logic [31:0] pend_idata;
  logic        ack_req;
  irq_id_t     ack_id;
  logic [31:0] rng_state;
  int          errors;
  int          cycles;
  string       test_name;

  mm_ram dut0 (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("** Error [%s] %s: expected %08h, actual %08h at %0t", test_name, what,
             expected, actual, $time);
  endtask

  // registered outputs are settled 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    cycles++;
    if (data_rvalid_o !== pend_dvalid)
      report_mismatch("data_rvalid_o", pend_dvalid, data_rvalid_o);
    if (pend_dvalid && pend_dread && data_rdata_o !== pend_drdata)
      report_mismatch("data_rdata_o", pend_drdata, data_rdata_o);
    if (instr_rvalid_o !== pend_ivalid)
      report_mismatch("instr_rvalid_o", pend_ivalid, instr_rvalid_o);
    if (pend_ivalid && instr_rdata_o !== pend_idata)
      report_mismatch("instr_rdata_o", pend_idata, instr_rdata_o);
  endtask

  task automatic bus_cycle(input logic do_data, input logic we, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic do_fetch, input logic [15:0] faddr);
    logic is_ram;
    logic mapped;
    logic exp_passed;
    logic exp_failed;
    logic exp_exit;
    next_cycle();
    data_req_i   = do_data;
    data_we_i    = we;
    data_addr_i  = addr;
    data_be_i    = be;
    data_wdata_i = wdata;
    instr_req_i  = do_fetch;
    instr_addr_i = faddr;
    irq_ack_i    = ack_req;
    irq_id_i     = ack_id;
    ack_req      = 1'b0;
    is_ram = (addr[31:16] == 16'h0);
    mapped = is_ram || addr == `MM_TEST_STATUS_ADDR || addr == `MM_EXIT_ADDR ||
             addr == `MM_TIMER_MASK_ADDR || addr == `MM_TIMER_CNT_ADDR;
    exp_passed = do_data && we && addr == `MM_TEST_STATUS_ADDR && wdata == `MM_PASS_MAGIC;
    exp_failed = do_data && we && addr == `MM_TEST_STATUS_ADDR && wdata == `MM_FAIL_MAGIC;
    exp_exit   = do_data && we && addr == `MM_EXIT_ADDR;
    #1;
    if (data_gnt_o !== (do_data && mapped))
      report_mismatch("data_gnt_o", do_data && mapped, data_gnt_o);
    if (instr_gnt_o !== do_fetch) report_mismatch("instr_gnt_o", do_fetch, instr_gnt_o);
    if (tests_passed_o !== exp_passed)
      report_mismatch("tests_passed_o", exp_passed, tests_passed_o);
    if (tests_failed_o !== exp_failed)
      report_mismatch("tests_failed_o", exp_failed, tests_failed_o);
    if (exit_valid_o !== exp_exit) report_mismatch("exit_valid_o", exp_exit, exit_valid_o);
    if (exp_exit && exit_value_o !== wdata)
      report_mismatch("exit_value_o", wdata, exit_value_o);
    // both ports read the word as it was before this cycle's write
    pend_dvalid = do_data && mapped;
    pend_dread  = do_data && !we;
    pend_drdata = is_ram ? model_mem[addr[15:2]] : 32'h0;
    pend_ivalid = do_fetch;
    pend_idata  = do_fetch ? model_mem[faddr[15:2]] : 32'h0;
    if (do_data && we && is_ram) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[addr[15:2]][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, 1'b0, 32'h0, 4'h0, 32'h0, 1'b0, 16'h0);
  endtask

  task automatic ack_cycle(input irq_id_t id);
    ack_req = 1'b1;
    ack_id  = id;
    idle_cycle();
  endtask

  task automatic expect_irq(input logic expected);
    if (irq_timer_o !== expected) report_mismatch("irq_timer_o", expected, irq_timer_o);
  endtask

  initial begin
    logic [31:0] r;
    logic [15:0] faddr;
    timer_cnt_t  n;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_wdata_i = '0;
    irq_id_i     = '0;
    irq_ack_i    = 1'b0;
    pend_dvalid  = 1'b0;
    pend_dread   = 1'b0;
    pend_drdata  = '0;
    pend_ivalid  = 1'b0;
    pend_idata   = '0;
    ack_req      = 1'b0;
    ack_id       = '0;
    rng_state    = 32'hcc20;
    errors       = 0;
    cycles       = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_name = "reset";
    if ({data_rvalid_o, instr_rvalid_o, tests_passed_o, tests_failed_o, exit_valid_o,
         irq_timer_o} !== 6'b0)
      report_mismatch("outputs after reset", 32'h0, {data_rvalid_o, instr_rvalid_o,
                      tests_passed_o, tests_failed_o, exit_valid_o, irq_timer_o});

    // host reads give zero, unmapped reads no grant
    test_name = "host";
    bus_cycle(1'b1, 1'b0, `MM_TEST_STATUS_ADDR, 4'hf, 32'h0, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b0, `MM_TIMER_CNT_ADDR, 4'hf, 32'h0, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b0, 32'h3000_0000, 4'hf, 32'h0, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_TEST_STATUS_ADDR, 4'hf, `MM_PASS_MAGIC, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_TEST_STATUS_ADDR, 4'hf, `MM_FAIL_MAGIC, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_TEST_STATUS_ADDR, 4'hf, next_rand(), 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_EXIT_ADDR, 4'hf, next_rand(), 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_EXIT_ADDR, 4'hf, next_rand(), 1'b0, 16'h0);

    test_name = "ram fill";
    for (int i = 0; i < FILL_WORDS; i++) begin
      r = next_rand();
      word_idx[i] = r[`MM_RAM_ADDR_WIDTH-1:2];
      bus_cycle(1'b1, 1'b1, {16'h0, word_idx[i], 2'b00}, 4'hf, next_rand(), 1'b0, 16'h0);
    end

    // back-to-back mix of byte writes, reads and fetches
    test_name = "ram random";
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r = next_rand();
      faddr = {word_idx[(r >> 8) % FILL_WORDS], 2'b00};
      bus_cycle(r[1:0] != 2'd3, r[1:0] < 2'd2, {16'h0, word_idx[(r >> 16) % FILL_WORDS], 2'b00},
                r[7:4], next_rand(), r[2], faddr);
    end

    test_name = "ram readback";
    for (int i = 0; i < FILL_WORDS; i++) begin
      faddr = {word_idx[i], 2'b00};
      bus_cycle(1'b1, 1'b0, {16'h0, faddr}, 4'hf, 32'h0, 1'b1, faddr);
    end

    test_name = "timer masked in";
    r = next_rand();
    n = timer_cnt_t'(r % TIMER_MAX + 1);
    bus_cycle(1'b1, 1'b1, `MM_TIMER_MASK_ADDR, 4'hf, 32'h1 << `MM_TIMER_IRQ_ID, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_TIMER_CNT_ADDR, 4'hf, n, 1'b0, 16'h0);
    for (int k = 0; k <= int'(n); k++) begin
      idle_cycle();
      expect_irq(k == int'(n));
    end
    repeat (3) begin
      idle_cycle();
      expect_irq(1'b1);
    end
    // an ack for another id leaves the timer irq alone
    ack_cycle(irq_id_t'(3));
    idle_cycle();
    expect_irq(1'b1);
    ack_cycle(irq_id_t'(`MM_TIMER_IRQ_ID));
    expect_irq(1'b1);
    idle_cycle();
    expect_irq(1'b0);

    test_name = "timer masked out";
    r = next_rand();
    n = timer_cnt_t'(r % TIMER_MAX + 1);
    bus_cycle(1'b1, 1'b1, `MM_TIMER_MASK_ADDR, 4'hf, 32'h0, 1'b0, 16'h0);
    bus_cycle(1'b1, 1'b1, `MM_TIMER_CNT_ADDR, 4'hf, n, 1'b0, 16'h0);
    for (int k = 0; k < int'(n) + 4; k++) begin
      idle_cycle();
      expect_irq(1'b0);
    end

    idle_cycle();
    idle_cycle();
    $display("cycles: %0d, errors: %0d", cycles, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // stop a stuck run once the whole sequence has had its time
  initial begin
    #(TEST_CYCLES * 20 + 2000);
    $display("timeout: test sequence did not finish after %0d cycles, errors: %0d",
             cycles, errors);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* mm_ram.f */
+incdir+hdl
hdl/mm_map_pkg.sv
hdl/mm_irq_pkg.sv
hdl/mm_data_if.sv
hdl/mm_addr_decode.sv
hdl/mm_ram_bank.sv
hdl/mm_host_regs.sv
hdl/mm_resp_stage.sv
hdl/mm_ram.sv
verification/tb_mm_ram.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mm_ram -f mm_ram.f -o sim_mm_ram \
  && ./obj_dir/sim_mm_ram > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
